//--- hdl/trig_pkg.sv
/* widths, limits and encodings shared by the front-panel trigger path
   channel count and DDR3 size are fixed for the digitizer board */
package trig_pkg;

  // channel setup
  localparam int num_chan = 5;          // digitizer channels
  localparam int burst_w  = 23;         // burst counts and stored-burst counters

  // storage limits, in bursts
  localparam int unsigned ddr3_bursts          = 8388608; // per channel, 2^23
  localparam int unsigned payload_limit_bursts = 104857;  // 2^20 words / 5 chan / 2 words per burst

  // counter widths
  localparam int trig_num_w  = 24;      // global trigger number
  localparam int timestamp_w = 44;      // cycle-count timestamp
  localparam int count_w     = 32;      // cumulative and overflow counters
  localparam int width_w     = 4;       // fp trigger width setting

  // one-hot state machine
  localparam int state_w       = 5;
  localparam int st_idle       = 0;     // armed, waiting for a pulse
  localparam int st_wait       = 1;     // monitoring pulse width
  localparam int st_ready_info = 2;     // info word being built
  localparam int st_store_info = 3;     // info word offered to FIFO
  localparam int st_rearm      = 4;     // waiting for trigger to fall

  // trigger-length codes
  localparam int         len_w     = 2;
  localparam logic [1:0] len_none  = 2'b00; // width monitoring off
  localparam logic [1:0] len_short = 2'b01;
  localparam logic [1:0] len_long  = 2'b10;
  localparam logic [1:0] len_mixed = 2'b11; // dropped and came back within window

  // trigger information word
  // {zeros, length code, trigger number, timestamp}, timestamp at bit 0
  localparam int info_w  = 128;
  localparam int ts_lsb  = 0;
  localparam int num_lsb = ts_lsb + timestamp_w;   // bit 44
  localparam int len_lsb = num_lsb + trig_num_w;   // bit 68
  localparam int pad_w   = info_w - len_lsb - len_w; // 58 zero bits on top

endpackage

//--- hdl/burst_occupancy_tracker.sv
/* counts bursts stored in DDR3 per channel and blocks triggers that would overflow
   DDR3 or the event payload; the payload check looks at channel 0 only */
`timescale 1ns/100ps

module burst_occupancy_tracker (
  input  logic clk,
  input  logic reset,
  input  logic readout_done,      // readout finished, DDR3 is free again
  input  logic pulse_trigger,     // one-cycle accepted trigger from receiver
  input  logic [trig_pkg::num_chan-1:0] chan_en,
  input  logic [trig_pkg::num_chan-1:0][trig_pkg::burst_w-1:0] burst_count,
  input  logic [trig_pkg::burst_w-1:0] thres_ddr3_overflow,
  output logic [trig_pkg::num_chan-1:0][trig_pkg::burst_w-1:0] stored_bursts,
  output logic storage_blocked,   // next trigger would not fit
  output logic ddr3_almost_full   // some channel above threshold
);
  import trig_pkg::*;

  // increment is burst_count + 1, so one extra bit
  logic [num_chan-1:0][burst_w:0] incr;
  logic [num_chan-1:0]            chan_full;  // per channel DDR3 room check
  logic [num_chan-1:0]            chan_warn;  // per channel threshold check
  logic                           payload_full;

  // room < incr is evaluated as stored + incr > limit, no wrap on subtraction
  always_comb begin
    for (int i = 0; i < num_chan; i++) begin
      if (chan_en[i]) begin
        incr[i] = {1'b0, burst_count[i]} + 1'b1;
      end else begin
        incr[i] = '0; // disabled channel stores nothing
      end
      chan_full[i] = ({2'b00, stored_bursts[i]} + {1'b0, incr[i]}) >
                     (burst_w + 2)'(ddr3_bursts);
      chan_warn[i] = stored_bursts[i] > thres_ddr3_overflow;
    end
  end

  // event payload limit, all channels assumed read identically
  assign payload_full = ({2'b00, stored_bursts[0]} + {1'b0, incr[0]}) >
                        (burst_w + 2)'(payload_limit_bursts);

  assign storage_blocked  = (|chan_full) | payload_full;
  assign ddr3_almost_full = |chan_warn;

  // stored-burst counters, one edge after the pulse trigger
  always_ff @(posedge clk) begin
    if (reset | readout_done) begin
      stored_bursts <= '0;
    end else if (pulse_trigger) begin
      for (int i = 0; i < num_chan; i++) begin
        stored_bursts[i] <= stored_bursts[i] + burst_w'(incr[i]); // fits, checked at accept
      end
    end
  end

endmodule

//--- hdl/pulse_trigger_receiver.sv
/* front-panel trigger FSM for asynchronous mode; one trigger in flight at a time
   and no new trigger is taken while the info FIFO applies back-pressure */
`timescale 1ns/100ps

module pulse_trigger_receiver (
  input  logic clk,
  input  logic reset,
  input  logic reset_trig_num,          // TTC channel B reset of trigger number
  input  logic reset_trig_timestamp,    // TTC channel B reset of timestamp
  input  logic trigger,                 // front-panel pulse
  input  logic [trig_pkg::width_w-1:0] fp_trig_width, // short/long boundary, 0 = off
  input  logic ttc_trigger,             // backplane trigger present
  input  logic ttc_acq_ready,           // channels ready to acquire
  input  logic accept_pulse_triggers,
  input  logic async_mode,
  input  logic readout_done,
  input  logic storage_blocked,         // from occupancy tracker
  input  logic fifo_ready,
  output logic pulse_trigger,           // one-cycle trigger to channels
  output logic [trig_pkg::trig_num_w-1:0] trig_num,
  output logic [trig_pkg::count_w-1:0]    accepted_ext_trigger_count,
  output logic [trig_pkg::trig_num_w-1:0] pulse_trigs_last_readout,
  output logic [trig_pkg::count_w-1:0]    ddr3_overflow_count,
  output logic fifo_valid,
  output logic [trig_pkg::info_w-1:0]     fifo_data,
  output logic [trig_pkg::state_w-1:0]    state
);
  import trig_pkg::*;

  logic [state_w-1:0]     next_state;
  logic [timestamp_w-1:0] timestamp_cnt;  // free-running cycle count
  logic [timestamp_w-1:0] trig_timestamp; // latched at accept
  logic [width_w-1:0]     wait_cnt;       // cycles spent monitoring width
  logic                   trig_went_lo;   // pulse dropped during the window
  logic [len_w-1:0]       trig_length;
  logic                   gate_open;
  logic                   accept;
  logic                   reject;
  logic                   wait_done;
  logic                   transfer;       // FIFO took the info word

  // all qualifiers for a front-panel pulse
  assign gate_open = trigger & async_mode & accept_pulse_triggers &
                     ~ttc_trigger & ttc_acq_ready;
  assign accept    = state[st_idle] & gate_open & ~storage_blocked;
  assign reject    = state[st_idle] & gate_open & storage_blocked; // would overflow
  assign wait_done = state[st_wait] & (wait_cnt == fp_trig_width);
  assign transfer  = state[st_store_info] & fifo_ready;

  // next-state logic, one bit set per state
  always_comb begin
    next_state = '0;
    case (1'b1)
      state[st_idle]: begin
        if (accept && fp_trig_width == '0) begin
          next_state[st_ready_info] = 1'b1; // no width monitoring
        end else if (accept) begin
          next_state[st_wait] = 1'b1;
        end else begin
          next_state[st_idle] = 1'b1;       // rejected or not gated in
        end
      end
      state[st_wait]: begin
        if (wait_done) next_state[st_ready_info] = 1'b1;
        else           next_state[st_wait]       = 1'b1;
      end
      state[st_ready_info]: next_state[st_store_info] = 1'b1;
      state[st_store_info]: begin
        if (!fifo_ready)  next_state[st_store_info] = 1'b1; // back-pressure, hold
        else if (trigger) next_state[st_rearm]      = 1'b1;
        else              next_state[st_idle]       = 1'b1;
      end
      state[st_rearm]: begin
        if (trigger) next_state[st_rearm] = 1'b1; // pulse still high
        else         next_state[st_idle]  = 1'b1;
      end
      default: next_state[st_idle] = 1'b1; // recover from a bad encoding
    endcase
  end

  // state, width monitor and overflow counter
  always_ff @(posedge clk) begin
    if (reset) begin
      state               <= state_w'(1 << st_idle);
      pulse_trigger       <= 1'b0;
      wait_cnt            <= '0;
      trig_went_lo        <= 1'b0;
      trig_length         <= len_none;
      ddr3_overflow_count <= '0;
    end else begin
      state         <= next_state;
      pulse_trigger <= accept;
      if (reject) ddr3_overflow_count <= ddr3_overflow_count + 1'b1; // every cycle held high

      if (accept) begin
        wait_cnt     <= width_w'(1); // accept edge is the first monitored cycle
        trig_went_lo <= 1'b0;
        trig_length  <= len_none;
      end else if (wait_done) begin
        if (!trigger)         trig_length <= len_short;
        else if (trig_went_lo) trig_length <= len_mixed;
        else                  trig_length <= len_long;
      end else if (state[st_wait]) begin
        wait_cnt <= wait_cnt + 1'b1;
        if (!trigger) trig_went_lo <= 1'b1; // caught low inside window
      end else if (transfer | state[st_idle]) begin
        wait_cnt     <= '0;
        trig_went_lo <= 1'b0;
        trig_length  <= len_none;
      end
    end
  end

  // trigger number, restarts at every readout
  always_ff @(posedge clk) begin
    if (reset | reset_trig_num | readout_done) begin
      trig_num <= '0;
    end else if (accept) begin
      trig_num <= trig_num + 1'b1; // first trigger is number 1
    end
  end

  // triggers held by the last readout; timestamp reset wins
  always_ff @(posedge clk) begin
    if (reset | reset_trig_timestamp) begin
      pulse_trigs_last_readout <= '0;
    end else if (reset_trig_num | readout_done) begin
      pulse_trigs_last_readout <= trig_num;
    end
  end

  // timestamp and cumulative count share the timestamp reset
  always_ff @(posedge clk) begin
    if (reset | reset_trig_timestamp) begin
      timestamp_cnt              <= '0;
      trig_timestamp             <= '0;
      accepted_ext_trigger_count <= '0;
    end else begin
      timestamp_cnt <= timestamp_cnt + 1'b1;
      if (accept) begin
        trig_timestamp             <= timestamp_cnt; // count value at accept edge
        accepted_ext_trigger_count <= accepted_ext_trigger_count + 1'b1;
      end
    end
  end

  // info word offered while in store state
  always_ff @(posedge clk) begin
    if (reset) fifo_valid <= 1'b0;
    else       fifo_valid <= next_state[st_store_info];
  end

  // built once on the way into store, so it stays stable under back-pressure
  always_ff @(posedge clk) begin
    if (state[st_ready_info]) begin
      fifo_data <= {{pad_w{1'b0}}, trig_length, trig_num, trig_timestamp};
    end
  end

endmodule

//--- hdl/trigger_info_fifo.sv
/* synchronous valid/ready FIFO for trigger info words
   depth must be a power of two, at least 2; read data is shown ahead */
`timescale 1ns/100ps

module trigger_info_fifo #(
  parameter int depth = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic wr_valid,
  input  logic [trig_pkg::info_w-1:0] wr_data,
  input  logic rd_ready,
  output logic wr_ready,              // not full
  output logic rd_valid,              // not empty
  output logic [trig_pkg::info_w-1:0] rd_data
);
  import trig_pkg::*;

  logic [info_w-1:0]          mem [depth];
  logic [$clog2(depth)-1:0]   wr_ptr;   // wraps on its own at power-of-two depth
  logic [$clog2(depth)-1:0]   rd_ptr;
  logic [$clog2(depth):0]     count;    // 0 .. depth
  logic                       wr_fire;
  logic                       rd_fire;

  assign wr_ready = count != ($clog2(depth) + 1)'(depth);
  assign rd_valid = count != '0;
  assign rd_data  = mem[rd_ptr];       // head word
  assign wr_fire  = wr_valid & wr_ready;
  assign rd_fire  = rd_valid & rd_ready;

  // storage
  always_ff @(posedge clk) begin
    if (wr_fire) mem[wr_ptr] <= wr_data;
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) wr_ptr <= wr_ptr + 1'b1;
      if (rd_fire) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;       // both or neither
      endcase
    end
  end

endmodule

//--- hdl/pulse_trigger_top.sv
/* front-panel trigger path in asynchronous mode: receiver, DDR3 occupancy
   tracker and trigger info FIFO; info words leave through a valid/ready port */
`timescale 1ns/100ps

module pulse_trigger_top (
  input  logic clk,
  input  logic reset,
  input  logic reset_trig_num,
  input  logic reset_trig_timestamp,
  input  logic trigger,               // front-panel pulse
  input  logic [trig_pkg::width_w-1:0] fp_trig_width,
  input  logic ttc_trigger,
  input  logic ttc_acq_ready,
  input  logic accept_pulse_triggers,
  input  logic async_mode,
  input  logic readout_done,
  input  logic [trig_pkg::num_chan-1:0] chan_en,
  input  logic [trig_pkg::num_chan-1:0][trig_pkg::burst_w-1:0] burst_count,
  input  logic [trig_pkg::burst_w-1:0] thres_ddr3_overflow,
  input  logic info_ready,            // downstream trigger processor
  output logic pulse_trigger,
  output logic [trig_pkg::trig_num_w-1:0] trig_num,
  output logic [trig_pkg::count_w-1:0]    accepted_ext_trigger_count,
  output logic [trig_pkg::trig_num_w-1:0] pulse_trigs_last_readout,
  output logic [trig_pkg::count_w-1:0]    ddr3_overflow_count,
  output logic [trig_pkg::state_w-1:0]    state,
  output logic [trig_pkg::num_chan-1:0][trig_pkg::burst_w-1:0] stored_bursts,
  output logic ddr3_almost_full,
  output logic info_valid,
  output logic [trig_pkg::info_w-1:0] info_data
);
  import trig_pkg::*;

  logic              storage_blocked; // tracker says next trigger won't fit
  logic              fifo_valid;
  logic              fifo_ready;
  logic [info_w-1:0] fifo_data;

  pulse_trigger_receiver u_receiver (
    .clk                        (clk),
    .reset                      (reset),
    .reset_trig_num             (reset_trig_num),
    .reset_trig_timestamp       (reset_trig_timestamp),
    .trigger                    (trigger),
    .fp_trig_width              (fp_trig_width),
    .ttc_trigger                (ttc_trigger),
    .ttc_acq_ready              (ttc_acq_ready),
    .accept_pulse_triggers      (accept_pulse_triggers),
    .async_mode                 (async_mode),
    .readout_done               (readout_done),
    .storage_blocked            (storage_blocked),
    .fifo_ready                 (fifo_ready),
    .pulse_trigger              (pulse_trigger),
    .trig_num                   (trig_num),
    .accepted_ext_trigger_count (accepted_ext_trigger_count),
    .pulse_trigs_last_readout   (pulse_trigs_last_readout),
    .ddr3_overflow_count        (ddr3_overflow_count),
    .fifo_valid                 (fifo_valid),
    .fifo_data                  (fifo_data),
    .state                      (state)
  );

  burst_occupancy_tracker u_tracker (
    .clk                 (clk),
    .reset               (reset),
    .readout_done        (readout_done),
    .pulse_trigger       (pulse_trigger),
    .chan_en             (chan_en),
    .burst_count         (burst_count),
    .thres_ddr3_overflow (thres_ddr3_overflow),
    .stored_bursts       (stored_bursts),
    .storage_blocked     (storage_blocked),
    .ddr3_almost_full    (ddr3_almost_full)
  );

  trigger_info_fifo u_info_fifo (
    .clk      (clk),
    .reset    (reset),
    .wr_valid (fifo_valid),
    .wr_data  (fifo_data),
    .rd_ready (info_ready),
    .wr_ready (fifo_ready),
    .rd_valid (info_valid),
    .rd_data  (info_data)
  );

endmodule

//--- dv/pulse_trigger_sva.sv
/* protocol checks on the trigger path, bound into the top level
   fifo_valid is the internal FIFO write valid of the top */
`timescale 1ns/100ps

module pulse_trigger_sva (
  input logic clk,
  input logic reset,
  input logic pulse_trigger,
  input logic fifo_valid,
  input logic fifo_ready,
  input logic [trig_pkg::info_w-1:0] fifo_data,
  input logic [trig_pkg::state_w-1:0] state,
  input logic info_valid,
  input logic info_ready,
  input logic [trig_pkg::info_w-1:0] info_data
);
  import trig_pkg::*;

  // channels must only ever see a one-cycle trigger
  a_pulse_one_cycle: assert property (@(posedge clk) disable iff (reset)
    pulse_trigger |=> !pulse_trigger)
    else $error("pulse_trigger high for two cycles in a row");

  // stalled head word stays put
  a_info_hold: assert property (@(posedge clk) disable iff (reset)
    info_valid && !info_ready |=> info_valid && $stable(info_data))
    else $error("info word dropped or changed while info_ready low");

  // full FIFO keeps the FSM parked in store with the same word offered
  a_wr_hold_in_store: assert property (@(posedge clk) disable iff (reset)
    fifo_valid && !fifo_ready |=> fifo_valid && state[st_store_info] && $stable(fifo_data))
    else $error("FIFO write word dropped or changed under back-pressure");

endmodule

bind pulse_trigger_top pulse_trigger_sva u_sva (
  .clk           (clk),
  .reset         (reset),
  .pulse_trigger (pulse_trigger),
  .fifo_valid    (fifo_valid),
  .fifo_ready    (fifo_ready),
  .fifo_data     (fifo_data),
  .state         (state),
  .info_valid    (info_valid),
  .info_ready    (info_ready),
  .info_data     (info_data)
);

//--- dv/tb_pulse_trigger.sv
/* directed testbench for the front-panel trigger path; expects the default FIFO depth of 4
   info_ready stays high except in the back-pressure test */
`timescale 1ns/100ps

module tb_pulse_trigger;
  import trig_pkg::*;

  localparam int fifo_depth  = 4;   // trigger_info_fifo default
  localparam int timeout_cyc = 200; // per wait loop

  logic clk = 1'b0;
  logic reset;
  logic reset_trig_num;
  logic reset_trig_timestamp;
  logic trigger;
  logic [width_w-1:0] fp_trig_width;
  logic ttc_trigger;
  logic ttc_acq_ready;
  logic accept_pulse_triggers;
  logic async_mode;
  logic readout_done;
  logic [num_chan-1:0] chan_en;
  logic [num_chan-1:0][burst_w-1:0] burst_count;
  logic [burst_w-1:0] thres_ddr3_overflow;
  logic info_ready;
  logic pulse_trigger;
  logic [trig_num_w-1:0] trig_num;
  logic [count_w-1:0] accepted_ext_trigger_count;
  logic [trig_num_w-1:0] pulse_trigs_last_readout;
  logic [count_w-1:0] ddr3_overflow_count;
  logic [state_w-1:0] state;
  logic [num_chan-1:0][burst_w-1:0] stored_bursts;
  logic ddr3_almost_full;
  logic info_valid;
  logic [info_w-1:0] info_data;

  // scoreboard and reference model
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int pulse_cnt = 0;                 // pulse_trigger cycles seen
  integer seed = 32'hf382;
  int unsigned exp_num = 0;          // trigger number
  int unsigned exp_acc = 0;          // cumulative accepted count
  int unsigned exp_ovf = 0;
  int unsigned exp_last = 0;
  int unsigned m_stored [num_chan];  // bursts per channel
  logic [timestamp_w-1:0] cyc;       // cycles since reset or timestamp reset
  logic [timestamp_w-1:0] ts_q [$];  // expected timestamp per accepted pulse
  logic [info_w-1:0] word_q [$];     // words read from the info port

  pulse_trigger_top DUT (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    if (reset || reset_trig_timestamp) cyc <= '0;
    else cyc <= cyc + 1'b1;
    if (pulse_trigger) begin
      pulse_cnt++;
      ts_q.push_back(cyc - 1'b1); // pulse shows one edge after the accept edge
    end
    if (info_valid && info_ready) word_q.push_back(info_data);
  end

  task automatic compare_info(input string name, input logic [info_w-1:0] exp, act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_count(input string name, input logic [count_w-1:0] exp, act);
    if (exp !== act) begin
      $display("ERR %s expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, act);
    if (exp !== act) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_bursts(input string name, input logic [burst_w-1:0] exp, act);
    if (exp !== act) begin
      $display("ERR %s expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int e0);
    tests_run++;
    if (errors != e0) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - e0);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  // drive trigger from bit 0 upward, one bit per cycle, then low
  task automatic send_pattern(input logic [15:0] bits, input int n);
    for (int i = 0; i < n; i++) begin
      trigger = bits[i];
      @(negedge clk);
    end
    trigger = 1'b0;
  endtask

  task automatic wait_idle(input string name);
    int t = 0;
    while (!state[st_idle] && t < timeout_cyc) begin
      @(negedge clk);
      t++;
    end
    if (!state[st_idle]) begin
      $display("%s: trigger FSM never got back to idle", name);
      errors++;
    end
  endtask

  task automatic trigger_once(input string name, input logic [15:0] bits, input int n);
    send_pattern(bits, n);
    wait_idle(name);
  endtask

  task automatic wait_words(input string name, input int n);
    int t = 0;
    while (word_q.size() < n && t < timeout_cyc) begin
      @(negedge clk);
      t++;
    end
    if (word_q.size() < n) begin
      $display("%s: only %0d of %0d info words arrived", name, word_q.size(), n);
      errors++;
    end
  endtask

  // expected word from the package layout and the recorded accept time
  task automatic check_word(input string name, input logic [len_w-1:0] len,
                            input logic [trig_num_w-1:0] num);
    logic [info_w-1:0] exp;
    if (word_q.size() == 0 || ts_q.size() == 0) begin
      $display("%s: no info word left to check", name);
      errors++;
      return;
    end
    exp = '0;
    exp[ts_lsb +: timestamp_w] = ts_q.pop_front();
    exp[num_lsb +: trig_num_w] = num;
    exp[len_lsb +: len_w]      = len;
    compare_info(name, exp, word_q.pop_front());
  endtask

  task automatic pulse_readout();
    readout_done = 1'b1;
    @(negedge clk);
    readout_done = 1'b0;
    exp_last = exp_num; // old number latched at the clearing edge
    exp_num  = 0;
    foreach (m_stored[i]) m_stored[i] = 0;
  endtask

  task automatic test_width0();
    int e0 = errors;
    int p0 = pulse_cnt;
    fp_trig_width = '0; // monitoring off
    for (int k = 0; k < 2; k++) begin
      trigger_once("width0", 16'h1, 1);
      exp_num++;
      exp_acc++;
      compare_count("width0 pulses", p0 + k + 1, pulse_cnt);
      compare_count("width0 trig_num", exp_num, trig_num);
      compare_count("width0 accepted", exp_acc, accepted_ext_trigger_count);
      repeat (5) @(negedge clk);
    end
    wait_words("width0", 2);
    if (word_q.size() >= 2 && ts_q.size() >= 2) begin
      compare_count("width0 ts delta", count_w'(ts_q[1] - ts_q[0]),
                    count_w'(word_q[1][timestamp_w-1:0] - word_q[0][timestamp_w-1:0]));
    end
    check_word("width0 word 1", len_none, exp_num - 1);
    check_word("width0 word 2", len_none, exp_num);
    finish_test("width0", e0);
  endtask

  task automatic test_width_class();
    int e0 = errors;
    fp_trig_width = 4'd6;
    trigger_once("short", 16'h0007, 3);     // gone before the window ends
    trigger_once("long", 16'h03ff, 10);     // high through the window
    trigger_once("mixed", 16'h03f3, 10);    // drops two cycles, comes back
    exp_num += 3;
    exp_acc += 3;
    wait_words("width class", 3);
    check_word("width short", len_short, exp_num - 2);
    check_word("width long", len_long, exp_num - 1);
    check_word("width mixed", len_mixed, exp_num);
    compare_count("width accepted", exp_acc, accepted_ext_trigger_count);
    fp_trig_width = '0;
    finish_test("width_class", e0);
  endtask

  task automatic test_gating();
    int e0 = errors;
    int p0 = pulse_cnt;
    for (int c = 0; c < 4; c++) begin
      async_mode            = (c != 0);
      accept_pulse_triggers = (c != 1);
      ttc_trigger           = (c == 2);
      ttc_acq_ready         = (c != 3);
      send_pattern(16'h1, 1);
      repeat (10) @(negedge clk);
    end
    async_mode            = 1'b1;
    accept_pulse_triggers = 1'b1;
    ttc_trigger           = 1'b0;
    ttc_acq_ready         = 1'b1;
    compare_count("gating pulses", p0, pulse_cnt);
    compare_count("gating trig_num", exp_num, trig_num);
    compare_count("gating accepted", exp_acc, accepted_ext_trigger_count);
    compare_count("gating overflow", exp_ovf, ddr3_overflow_count);
    compare_count("gating words", 0, word_q.size());
    finish_test("gating", e0);
  endtask

  task automatic test_occupancy();
    int e0 = errors;
    int unsigned inc [num_chan];
    logic blocked;
    logic exp_af;
    pulse_readout(); // start from empty DDR3
    chan_en = 5'b10111;
    thres_ddr3_overflow = 23'd1500;
    for (int t = 0; t < 6; t++) begin
      for (int i = 0; i < num_chan; i++) begin
        burst_count[i] = burst_w'($random(seed)) & 23'h3ff;
      end
      if (t >= 3) burst_count[0] = 23'd60000; // two of these exceed the payload
      blocked = 1'b0;
      for (int i = 0; i < num_chan; i++) begin
        inc[i] = chan_en[i] ? burst_count[i] + 1 : 0;
        if (m_stored[i] + inc[i] > ddr3_bursts) blocked = 1'b1;
      end
      if (m_stored[0] + inc[0] > payload_limit_bursts) blocked = 1'b1;
      trigger_once("occupancy", 16'h1, 1);
      repeat (2) @(negedge clk);
      if (blocked) begin
        exp_ovf++;
      end else begin
        exp_num++;
        exp_acc++;
        foreach (m_stored[i]) m_stored[i] += inc[i];
        wait_words("occupancy", 1);
        check_word("occupancy word", len_none, exp_num);
      end
      exp_af = 1'b0;
      for (int i = 0; i < num_chan; i++) begin
        compare_bursts("occupancy stored", burst_w'(m_stored[i]), stored_bursts[i]);
        if (m_stored[i] > thres_ddr3_overflow) exp_af = 1'b1;
      end
      compare_flag("occupancy almost_full", exp_af, ddr3_almost_full);
      compare_count("occupancy overflow", exp_ovf, ddr3_overflow_count);
      compare_count("occupancy trig_num", exp_num, trig_num);
    end
    finish_test("occupancy", e0);
  endtask

  task automatic test_readout();
    int e0 = errors;
    pulse_readout();
    compare_count("readout trig_num", exp_num, trig_num);
    compare_count("readout last", exp_last, pulse_trigs_last_readout);
    compare_flag("readout almost_full", 1'b0, ddr3_almost_full);
    for (int i = 0; i < num_chan; i++) begin
      compare_bursts("readout stored", '0, stored_bursts[i]);
    end
    burst_count = '0;
    trigger_once("readout", 16'h1, 1);
    exp_num++;
    exp_acc++;
    wait_words("readout", 1);
    check_word("readout word", len_none, exp_num);
    reset_trig_timestamp = 1'b1;
    @(negedge clk);
    reset_trig_timestamp = 1'b0;
    exp_acc  = 0;
    exp_last = 0;
    compare_count("ts reset accepted", exp_acc, accepted_ext_trigger_count);
    compare_count("ts reset last", exp_last, pulse_trigs_last_readout);
    compare_count("ts reset trig_num", exp_num, trig_num); // number survives
    finish_test("readout", e0);
  endtask

  task automatic test_backpressure();
    int e0 = errors;
    int p0 = pulse_cnt;
    info_ready = 1'b0;
    for (int t = 0; t < fifo_depth + 3; t++) begin
      send_pattern(16'h1, 1);
      repeat (8) @(negedge clk);
    end
    exp_num += fifo_depth + 1; // four queued, one held in store
    exp_acc += fifo_depth + 1;
    compare_count("backpressure pulses", p0 + fifo_depth + 1, pulse_cnt);
    compare_count("backpressure trig_num", exp_num, trig_num);
    compare_count("backpressure accepted", exp_acc, accepted_ext_trigger_count);
    compare_flag("backpressure store", 1'b1, state[st_store_info]);
    info_ready = 1'b1;
    wait_words("backpressure", fifo_depth + 1);
    for (int k = fifo_depth; k >= 0; k--) begin
      check_word("backpressure word", len_none, exp_num - k);
    end
    wait_idle("backpressure");
    finish_test("backpressure", e0);
  endtask

  initial begin
    reset                 = 1'b1;
    reset_trig_num        = 1'b0;
    reset_trig_timestamp  = 1'b0;
    trigger               = 1'b0;
    fp_trig_width         = '0;
    ttc_trigger           = 1'b0;
    ttc_acq_ready         = 1'b1;
    accept_pulse_triggers = 1'b1;
    async_mode            = 1'b1;
    readout_done          = 1'b0;
    chan_en               = '1;
    burst_count           = '0;
    thres_ddr3_overflow   = '1;
    info_ready            = 1'b1;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    test_width0();
    test_width_class();
    test_gating();
    test_occupancy();
    test_readout();
    test_backpressure();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- compile.f
hdl/trig_pkg.sv
hdl/burst_occupancy_tracker.sv
hdl/pulse_trigger_receiver.sv
hdl/trigger_info_fifo.sv
hdl/pulse_trigger_top.sv
dv/pulse_trigger_sva.sv
dv/tb_pulse_trigger.sv

//--- Bender.yml
package:
  name: pulse_trigger

sources:
  - hdl/trig_pkg.sv
  - hdl/burst_occupancy_tracker.sv
  - hdl/pulse_trigger_receiver.sv
  - hdl/trigger_info_fifo.sv
  - hdl/pulse_trigger_top.sv
  - target: test
    files:
      - dv/pulse_trigger_sva.sv
      - dv/tb_pulse_trigger.sv
